//--- vlog.f
source/tanimoto_pkg.sv
source/vector_decode.sv
source/threshold_table.sv
source/similarity_execute.sv
source/match_result.sv
source/tanimoto_top.sv
testbench/tanimoto_tb_assert.sv
testbench/tanimoto_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tanimoto_tb -o tanimoto_sim > build.log 2>&1 \
    && ./obj_dir/tanimoto_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "^Testbench passed$" sim.log \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail (see build.log and sim.log)"; exit 1; }

//--- testbench/tanimoto_tb.sv
`timescale 1ns/1ps

module tanimoto_tb;
    import tanimoto_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int TABLE_SIZE = 2 * VEC_WIDTH + 1;
    localparam int RAND_CANDS = 50;
    // Streamed beats over all runs including references
    localparam int STREAM_BEATS    = 4 * REF_NUM + 2 + 2 * RAND_CANDS + 4;
    localparam int APB_OPS         = 3 * TABLE_SIZE + 12;
    localparam int WATCHDOG_CYCLES = STREAM_BEATS * 40 + APB_OPS * 4 + 200;

    logic                 clk;
    logic                 rstn;
    logic [VEC_WIDTH-1:0] i_vec;
    logic                 i_last;
    logic                 i_valid;
    logic                 o_ready;
    apb_req_t             apb;
    logic [CNT_WIDTH-1:0] o_prdata;
    pair_t                o_pair;
    logic                 o_pair_valid;
    logic                 i_pair_ready;

    // Model state
    logic [VEC_WIDTH-1:0] ref_model [REF_NUM];
    logic [CNT_WIDTH-1:0] thr_model [TABLE_SIZE];
    logic [ID_WIDTH-1:0]  model_id;
    pair_t                exp_q [$];
    pair_t                exp_pair;
    logic [CNT_WIDTH-1:0] rd_data;
    int                   checks;
    int                   errors;
    int                   pairs_seen;
    int                   pairs_before;
    int                   checks_before;
    int                   errors_before;
    logic                 ready_random;

    tanimoto_top #(
        .VEC_WIDTH (VEC_WIDTH),
        .REF_NUM   (REF_NUM),
        .ID_WIDTH  (ID_WIDTH)
    ) dut_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_vec        (i_vec),
        .i_last       (i_last),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .i_apb        (apb),
        .o_prdata     (o_prdata),
        .o_pair       (o_pair),
        .o_pair_valid (o_pair_valid),
        .i_pair_ready (i_pair_ready)
    );

    bind tanimoto_top tanimoto_tb_assert u_assert (
        .clk          (clk),
        .rstn         (rstn),
        .i_apb        (i_apb),
        .i_cand_valid (cand_valid),
        .i_cand_last  (cand_last),
        .o_ready      (o_ready),
        .o_pair       (o_pair),
        .o_pair_valid (o_pair_valid),
        .i_pair_ready (i_pair_ready)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Tanimoto rule against the written table, AND count versus the entry at count(A) + count(B)
    function automatic logic [REF_NUM-1:0] expected_mask(input logic [VEC_WIDTH-1:0] cand);
        logic [REF_NUM-1:0] mask;
        int                 cnt_a;
        int                 cnt_b;
        int                 cnt_and;
        mask  = '0;
        cnt_b = $countones(cand);
        for (int r = 0; r < REF_NUM; r++) begin
            cnt_a   = $countones(ref_model[r]);
            cnt_and = $countones(ref_model[r] & cand);
            mask[r] = cnt_and >= int'(thr_model[cnt_a + cnt_b]);
        end
        return mask;
    endfunction

    // Output beats are compared in order as they transfer
    always @(posedge clk) begin
        if (rstn && o_pair_valid && i_pair_ready) begin
            pairs_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("A pair beat came out when none was expected at %0t", $time);
            end else begin
                exp_pair = exp_q.pop_front();
                check_value("o_pair.ref_idx", o_pair.ref_idx, exp_pair.ref_idx);
                check_value("o_pair.id", o_pair.id, exp_pair.id);
                check_value("o_pair.last", o_pair.last, exp_pair.last);
            end
        end
    end

    always @(negedge clk) begin
        if (ready_random) begin
            i_pair_ready = ($urandom_range(0, 9) < 3);
        end
    end

    // Tasks below start and end on a falling edge
    task automatic apb_write(input int addr, input logic [CNT_WIDTH-1:0] data);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b1;
        apb.paddr   = SUM_WIDTH'(addr);
        apb.pwdata  = data;
        @(negedge clk);
        apb.penable = 1'b1;
        @(negedge clk);
        apb = '0;
        if (addr <= 2 * VEC_WIDTH) begin
            thr_model[addr] = data;
        end
    endtask

    task automatic apb_read(input int addr, output logic [CNT_WIDTH-1:0] data);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
        apb.paddr   = SUM_WIDTH'(addr);
        apb.pwdata  = '0;
        @(negedge clk);
        apb.penable = 1'b1;
        @(posedge clk);
        data = o_prdata;
        @(negedge clk);
        apb = '0;
    endtask

    task automatic send_vec(input logic [VEC_WIDTH-1:0] vec, input logic last);
        i_vec   = vec;
        i_last  = last;
        i_valid = 1'b1;
        @(posedge clk);
        while (!o_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        i_valid = 1'b0;
        i_last  = 1'b0;
    endtask

    task automatic load_refs();
        model_id = '0;
        for (int r = 0; r < REF_NUM; r++) begin
            send_vec(ref_model[r], 1'b0);
        end
    endtask

    task automatic send_cand(input logic [VEC_WIDTH-1:0] vec, input logic last);
        logic [REF_NUM-1:0] mask;
        pair_t              p;
        mask = expected_mask(vec);
        for (int r = 0; r < REF_NUM; r++) begin
            if (mask[r]) begin
                p.ref_idx = REF_IDX_WIDTH'(r);
                p.id      = model_id;
                p.last    = 1'b0;
                exp_q.push_back(p);
            end
        end
        if (last) begin
            p = '0;
            p.last = 1'b1;
            exp_q.push_back(p);
        end
        model_id++;
        send_vec(vec, last);
    endtask

    task automatic program_identity();
        for (int s = 0; s < TABLE_SIZE; s++) begin
            apb_write(s, CNT_WIDTH'(s / 2));
        end
    endtask

    task automatic program_random();
        for (int s = 0; s < TABLE_SIZE; s++) begin
            apb_write(s, CNT_WIDTH'($urandom_range(s / 4, s / 2 + 1)));
        end
    endtask

    task automatic random_run(input int n);
        logic [VEC_WIDTH-1:0] vec;
        int                   k;
        for (int r = 0; r < REF_NUM; r++) begin
            ref_model[r] = $urandom;
        end
        load_refs();
        for (int i = 0; i < n; i++) begin
            k = $urandom_range(0, REF_NUM - 1);
            // Mostly near a reference with a few bits flipped
            if ($urandom_range(0, 3) == 0) begin
                vec = $urandom;
            end else begin
                vec = ref_model[k] ^ ($urandom & $urandom & $urandom);
            end
            send_cand(vec, i == n - 1);
        end
    endtask

    task automatic drain_run();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
    endtask

    task automatic start_test();
        checks_before = checks;
        errors_before = errors;
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d %s: %0d checks, %0d errors", num, name,
                 checks - checks_before, errors - errors_before);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the run never completed", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(57));
        rstn         = 1'b0;
        i_vec        = '0;
        i_last       = 1'b0;
        i_valid      = 1'b0;
        apb          = '0;
        i_pair_ready = 1'b1;
        ready_random = 1'b0;
        model_id     = '0;
        checks       = 0;
        errors       = 0;
        pairs_seen   = 0;
        for (int s = 0; s < TABLE_SIZE; s++) begin
            thr_model[s] = NEVER_MATCH;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        start_test();
        check_value("o_pair_valid", o_pair_valid, 1'b0);
        check_value("o_ready", o_ready, 1'b1);
        apb_read(0, rd_data);
        check_value("o_prdata", rd_data, NEVER_MATCH);
        apb_read(VEC_WIDTH, rd_data);
        check_value("o_prdata", rd_data, NEVER_MATCH);
        apb_read(2 * VEC_WIDTH, rd_data);
        check_value("o_prdata", rd_data, NEVER_MATCH);
        apb_write(5, 3);
        apb_write(2 * VEC_WIDTH, 20);
        apb_write(2 * VEC_WIDTH + 20, 9);
        apb_read(5, rd_data);
        check_value("o_prdata", rd_data, 3);
        apb_read(2 * VEC_WIDTH, rd_data);
        check_value("o_prdata", rd_data, 20);
        apb_read(2 * VEC_WIDTH + 20, rd_data);
        check_value("o_prdata", rd_data, 0);
        report_test(1, "reset and table access");

        // A copy of one reference matches only that one since the bit fields are disjoint
        start_test();
        program_identity();
        for (int r = 0; r < REF_NUM; r++) begin
            for (int b = 0; b < VEC_WIDTH; b++) begin
                ref_model[r][b] = (b / (VEC_WIDTH / REF_NUM)) == r;
            end
        end
        load_refs();
        pairs_before = pairs_seen;
        send_cand(ref_model[0], 1'b0);
        send_cand(ref_model[2], 1'b1);
        drain_run();
        check_value("pair_count", pairs_seen - pairs_before, 3);
        report_test(2, "identity matches");

        start_test();
        program_random();
        random_run(RAND_CANDS);
        drain_run();
        report_test(3, "random table and vectors");

        start_test();
        ready_random = 1'b1;
        random_run(RAND_CANDS);
        drain_run();
        ready_random = 1'b0;
        i_pair_ready = 1'b1;
        report_test(4, "output back-pressure");

        // Interleaved references with IDs restarting at zero
        start_test();
        program_identity();
        for (int r = 0; r < REF_NUM; r++) begin
            for (int b = 0; b < VEC_WIDTH; b++) begin
                ref_model[r][b] = (b % REF_NUM) == r;
            end
        end
        load_refs();
        send_cand(ref_model[REF_NUM - 1], 1'b0);
        send_cand(ref_model[1], 1'b0);
        send_cand($urandom, 1'b0);
        send_cand(ref_model[0], 1'b1);
        drain_run();
        report_test(5, "second run with new references");

        $display("Totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- testbench/tanimoto_tb_assert.sv
`timescale 1ns/1ps

module tanimoto_tb_assert (
    input logic                   clk,
    input logic                   rstn,
    input tanimoto_pkg::apb_req_t i_apb,
    input logic                   i_cand_valid,
    input logic                   i_cand_last,
    input logic                   o_ready,
    input tanimoto_pkg::pair_t    o_pair,
    input logic                   o_pair_valid,
    input logic                   i_pair_ready
);

    // A stalled beat keeps its value until it transfers
    pair_hold: assert property (@(posedge clk) disable iff (!rstn)
        (o_pair_valid && !i_pair_ready) |=> (o_pair_valid && $stable(o_pair)))
        else $error("o_pair changed or dropped while stalled");

    // Access phase only right after a setup phase
    apb_access: assert property (@(posedge clk) disable iff (!rstn)
        i_apb.penable |-> (i_apb.psel && $past(i_apb.psel && !i_apb.penable)))
        else $error("APB penable without a preceding setup phase");

    // Decode flags the last candidate one cycle after acceptance
    last_stall: assert property (@(posedge clk) disable iff (!rstn)
        (i_cand_valid && i_cand_last) |-> !o_ready)
        else $error("o_ready high after the last candidate was accepted");

endmodule

//--- source/tanimoto_top.sv
`timescale 1ns/1ps

module tanimoto_top #(
    parameter int VEC_WIDTH = tanimoto_pkg::VEC_WIDTH,
    parameter int REF_NUM   = tanimoto_pkg::REF_NUM,
    parameter int ID_WIDTH  = tanimoto_pkg::ID_WIDTH
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [VEC_WIDTH-1:0]              i_vec,
    input  logic                              i_last,
    input  logic                              i_valid,
    output logic                              o_ready,
    input  tanimoto_pkg::apb_req_t            i_apb,
    output logic [tanimoto_pkg::CNT_WIDTH-1:0] o_prdata,
    output tanimoto_pkg::pair_t               o_pair,
    output logic                              o_pair_valid,
    input  logic                              i_pair_ready
);
    import tanimoto_pkg::*;

    cand_t                        cand;
    logic                         cand_valid;
    logic                         cand_last;
    logic [REF_NUM*VEC_WIDTH-1:0] ref_bank;
    logic [REF_NUM*CNT_WIDTH-1:0] ref_cnts;
    logic [REF_NUM*SUM_WIDTH-1:0] lookup_addr;
    logic [REF_NUM*CNT_WIDTH-1:0] lookup_min;
    mask_item_t                   item;
    logic                         item_valid;
    logic                         queue_space;
    logic                         run_end;

    vector_decode #(
        .VEC_WIDTH (VEC_WIDTH),
        .REF_NUM   (REF_NUM),
        .ID_WIDTH  (ID_WIDTH)
    ) u_decode (
        .clk           (clk),
        .rstn          (rstn),
        .i_vec         (i_vec),
        .i_last        (i_last),
        .i_valid       (i_valid),
        .o_ready       (o_ready),
        .o_cand        (cand),
        .o_cand_valid  (cand_valid),
        .o_cand_last   (cand_last),
        .o_ref_bank    (ref_bank),
        .o_ref_cnts    (ref_cnts),
        .i_queue_space (queue_space),
        .i_run_end     (run_end)
    );

    threshold_table #(
        .VEC_WIDTH (VEC_WIDTH),
        .REF_NUM   (REF_NUM)
    ) u_table (
        .clk           (clk),
        .rstn          (rstn),
        .i_apb         (i_apb),
        .o_prdata      (o_prdata),
        .i_lookup_addr (lookup_addr),
        .o_lookup_min  (lookup_min)
    );

    similarity_execute #(
        .VEC_WIDTH (VEC_WIDTH),
        .REF_NUM   (REF_NUM)
    ) u_execute (
        .clk           (clk),
        .rstn          (rstn),
        .i_cand        (cand),
        .i_cand_valid  (cand_valid),
        .i_cand_last   (cand_last),
        .i_ref_bank    (ref_bank),
        .i_ref_cnts    (ref_cnts),
        .o_lookup_addr (lookup_addr),
        .i_lookup_min  (lookup_min),
        .o_item        (item),
        .o_item_valid  (item_valid)
    );

    match_result #(
        .REF_NUM (REF_NUM)
    ) u_result (
        .clk           (clk),
        .rstn          (rstn),
        .i_item        (item),
        .i_item_valid  (item_valid),
        .o_queue_space (queue_space),
        .o_pair        (o_pair),
        .o_pair_valid  (o_pair_valid),
        .i_pair_ready  (i_pair_ready),
        .o_run_end     (run_end)
    );

endmodule

//--- source/match_result.sv
`timescale 1ns/1ps

module match_result #(
    parameter int REF_NUM = tanimoto_pkg::REF_NUM
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  tanimoto_pkg::mask_item_t i_item,
    input  logic                     i_item_valid,
    output logic                     o_queue_space,
    output tanimoto_pkg::pair_t      o_pair,
    output logic                     o_pair_valid,
    input  logic                     i_pair_ready,
    output logic                     o_run_end
);
    import tanimoto_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int PTR_WIDTH   = $clog2(QUEUE_DEPTH);
    // Decode and stage 1 may each still hold an item, plus the new acceptance
    localparam int RESERVE     = 3;

    mask_item_t               queue_mem [QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0]     wr_ptr;
    logic [PTR_WIDTH-1:0]     rd_ptr;
    logic [PTR_WIDTH:0]       count;
    logic [PTR_WIDTH+1:0]     fill;
    mask_item_t               head;
    logic [REF_NUM-1:0]       done_mask;
    logic [REF_NUM-1:0]       pending;
    logic [REF_NUM-1:0]       low_bit;
    logic [REF_IDX_WIDTH-1:0] low_idx;
    logic                     last_pending;
    logic                     pair_fire;
    logic                     pop;

    // Item at the queue input already counts as occupying a slot
    assign fill          = (PTR_WIDTH + 2)'(count) + (PTR_WIDTH + 2)'(i_item_valid);
    assign o_queue_space = fill <= (PTR_WIDTH + 2)'(QUEUE_DEPTH - RESERVE);

    always_ff @(posedge clk) begin
        if (i_item_valid) begin
            queue_mem[wr_ptr] <= i_item;
        end
    end

    assign head = queue_mem[rd_ptr];

    // Match bits of the head item not yet sent
    assign pending = (count != '0) ? (head.mask & ~done_mask) : '0;
    assign low_bit = pending & (~pending + 1'b1);

    always_comb begin
        low_idx = '0;
        for (int i = REF_NUM - 1; i >= 0; i--) begin
            if (pending[i]) begin
                low_idx = REF_IDX_WIDTH'(i);
            end
        end
    end

    assign o_pair_valid = last_pending || (pending != '0);
    assign pair_fire    = o_pair_valid && i_pair_ready;
    assign o_run_end    = last_pending && i_pair_ready;

    // Pop on the beat of the highest set bit, or at once for an empty mask
    assign pop = !last_pending && (count != '0) &&
                 ((pending == '0) || (pair_fire && (pending == low_bit)));

    always_comb begin
        o_pair = '0;
        if (last_pending) begin
            o_pair.last = 1'b1;
        end else begin
            o_pair.ref_idx = low_idx;
            o_pair.id      = head.id;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            done_mask    <= '0;
            last_pending <= 1'b0;
        end else begin
            if (i_item_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_WIDTH + 1)'(i_item_valid) - (PTR_WIDTH + 1)'(pop);

            if (pop) begin
                done_mask <= '0;
            end else if (pair_fire && !last_pending) begin
                done_mask <= done_mask | low_bit;
            end

            // End-of-run beat follows the item that carries the last candidate
            if (o_run_end) begin
                last_pending <= 1'b0;
            end else if (pop && head.last) begin
                last_pending <= 1'b1;
            end
        end
    end

endmodule

//--- source/similarity_execute.sv
`timescale 1ns/1ps

module similarity_execute #(
    parameter int VEC_WIDTH = tanimoto_pkg::VEC_WIDTH,
    parameter int REF_NUM   = tanimoto_pkg::REF_NUM
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  tanimoto_pkg::cand_t                       i_cand,
    input  logic                                      i_cand_valid,
    input  logic                                      i_cand_last,
    input  logic [REF_NUM*VEC_WIDTH-1:0]              i_ref_bank,
    input  logic [REF_NUM*tanimoto_pkg::CNT_WIDTH-1:0] i_ref_cnts,
    output logic [REF_NUM*tanimoto_pkg::SUM_WIDTH-1:0] o_lookup_addr,
    input  logic [REF_NUM*tanimoto_pkg::CNT_WIDTH-1:0] i_lookup_min,
    output tanimoto_pkg::mask_item_t                  o_item,
    output logic                                      o_item_valid
);
    import tanimoto_pkg::*;

    // Stage 1 registers
    logic                 s1_valid;
    logic                 s1_last;
    logic [ID_WIDTH-1:0]  s1_id;
    logic [CNT_WIDTH-1:0] s1_cand_cnt;
    logic [CNT_WIDTH-1:0] s1_and_cnt [REF_NUM];
    logic [CNT_WIDTH-1:0] s1_ref_cnt [REF_NUM];

    // Stage 2 compare result
    logic [REF_NUM-1:0]   match;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= i_cand_valid;
        end
    end

    // Counts for candidate B and each A & B
    always_ff @(posedge clk) begin
        if (i_cand_valid) begin
            s1_id       <= i_cand.id;
            s1_last     <= i_cand_last;
            s1_cand_cnt <= popcount(i_cand.vec);
            for (int r = 0; r < REF_NUM; r++) begin
                s1_and_cnt[r] <= popcount(i_cand.vec & i_ref_bank[r*VEC_WIDTH +: VEC_WIDTH]);
                // Snapshot of count(A) travels with the candidate
                s1_ref_cnt[r] <= i_ref_cnts[r*CNT_WIDTH +: CNT_WIDTH];
            end
        end
    end

    for (genvar r = 0; r < REF_NUM; r++) begin : g_compare
        // count(A) + count(B) addresses the threshold table
        assign o_lookup_addr[r*SUM_WIDTH +: SUM_WIDTH] =
            SUM_WIDTH'(s1_ref_cnt[r]) + SUM_WIDTH'(s1_cand_cnt);
        assign match[r] = s1_and_cnt[r] >= i_lookup_min[r*CNT_WIDTH +: CNT_WIDTH];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_item_valid <= 1'b0;
        end else begin
            o_item_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            o_item.id   <= s1_id;
            o_item.mask <= match;
            o_item.last <= s1_last;
        end
    end

endmodule

//--- source/threshold_table.sv
`timescale 1ns/1ps

module threshold_table #(
    parameter int VEC_WIDTH = tanimoto_pkg::VEC_WIDTH,
    parameter int REF_NUM   = tanimoto_pkg::REF_NUM
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  tanimoto_pkg::apb_req_t                    i_apb,
    output logic [tanimoto_pkg::CNT_WIDTH-1:0]         o_prdata,
    input  logic [REF_NUM*tanimoto_pkg::SUM_WIDTH-1:0] i_lookup_addr,
    output logic [REF_NUM*tanimoto_pkg::CNT_WIDTH-1:0] o_lookup_min
);
    import tanimoto_pkg::*;

    // One entry per possible count(A) + count(B)
    localparam int TABLE_SIZE = 2 * VEC_WIDTH + 1;

    logic [CNT_WIDTH-1:0] thr_table [TABLE_SIZE];
    logic                 addr_ok;
    logic                 access;
    logic                 wr_en;

    assign addr_ok = i_apb.paddr <= SUM_WIDTH'(2 * VEC_WIDTH);
    // Access phase, the transfer completes in this cycle
    assign access  = i_apb.psel && i_apb.penable;
    assign wr_en   = access && i_apb.pwrite && addr_ok;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                thr_table[i] <= NEVER_MATCH;
            end
        end else if (wr_en) begin
            thr_table[i_apb.paddr] <= i_apb.pwdata;
        end
    end

    // Out-of-range addresses read as zero
    assign o_prdata = (access && addr_ok) ? thr_table[i_apb.paddr] : '0;

    // Parallel lookups, one per reference slot
    for (genvar r = 0; r < REF_NUM; r++) begin : g_lookup
        assign o_lookup_min[r*CNT_WIDTH +: CNT_WIDTH] =
            thr_table[i_lookup_addr[r*SUM_WIDTH +: SUM_WIDTH]];
    end

endmodule

//--- source/vector_decode.sv
`timescale 1ns/1ps

module vector_decode #(
    parameter int VEC_WIDTH = tanimoto_pkg::VEC_WIDTH,
    parameter int REF_NUM   = tanimoto_pkg::REF_NUM,
    parameter int ID_WIDTH  = tanimoto_pkg::ID_WIDTH
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic [VEC_WIDTH-1:0]                      i_vec,
    input  logic                                      i_last,
    input  logic                                      i_valid,
    output logic                                      o_ready,
    output tanimoto_pkg::cand_t                       o_cand,
    output logic                                      o_cand_valid,
    output logic                                      o_cand_last,
    output logic [REF_NUM*VEC_WIDTH-1:0]              o_ref_bank,
    output logic [REF_NUM*tanimoto_pkg::CNT_WIDTH-1:0] o_ref_cnts,
    input  logic                                      i_queue_space,
    input  logic                                      i_run_end
);
    import tanimoto_pkg::*;

    typedef enum logic [1:0] {
        ST_LOAD,
        ST_STREAM,
        ST_WAIT
    } state_t;

    state_t                   state;
    logic [REF_IDX_WIDTH-1:0] ref_slot;
    logic [ID_WIDTH-1:0]      cand_id;
    logic                     accept;

    // References load regardless of queue fill, candidates need room downstream
    assign o_ready = (state == ST_LOAD) || ((state == ST_STREAM) && i_queue_space);
    assign accept  = i_valid && o_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= ST_LOAD;
            ref_slot     <= '0;
            cand_id      <= '0;
            o_cand_valid <= 1'b0;
        end else begin
            o_cand_valid <= 1'b0;
            case (state)
                ST_LOAD: begin
                    // i_last is ignored here, the beat is just another reference
                    if (accept) begin
                        if (ref_slot == REF_IDX_WIDTH'(REF_NUM - 1)) begin
                            ref_slot <= '0;
                            state    <= ST_STREAM;
                        end else begin
                            ref_slot <= ref_slot + 1'b1;
                        end
                    end
                end
                ST_STREAM: begin
                    if (accept) begin
                        o_cand_valid <= 1'b1;
                        cand_id      <= cand_id + 1'b1;
                        if (i_last) begin
                            state <= ST_WAIT;
                        end
                    end
                end
                ST_WAIT: begin
                    // Hold input off until the end-of-run beat has left
                    if (i_run_end) begin
                        state   <= ST_LOAD;
                        cand_id <= '0;
                    end
                end
                default: state <= ST_LOAD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && (state == ST_LOAD)) begin
            o_ref_bank[ref_slot*VEC_WIDTH +: VEC_WIDTH] <= i_vec;
            o_ref_cnts[ref_slot*CNT_WIDTH +: CNT_WIDTH] <= popcount(i_vec);
        end
        if (accept && (state == ST_STREAM)) begin
            o_cand.vec  <= i_vec;
            o_cand.id   <= cand_id;
            o_cand_last <= i_last;
        end
    end

endmodule

//--- source/tanimoto_pkg.sv
package tanimoto_pkg;

    // Defaults for the module parameters set in tanimoto_top
    localparam int VEC_WIDTH = 32;
    localparam int REF_NUM   = 4;
    localparam int ID_WIDTH  = 8;

    // Bit count covers 0 to VEC_WIDTH inclusive
    localparam int CNT_WIDTH     = $clog2(VEC_WIDTH + 1);
    // Sum of two counts, also the threshold table address
    localparam int SUM_WIDTH     = $clog2(2 * VEC_WIDTH + 1);
    localparam int REF_IDX_WIDTH = (REF_NUM > 1) ? $clog2(REF_NUM) : 1;

    // No AND count can reach this, so an unprogrammed entry never matches
    localparam logic [CNT_WIDTH-1:0] NEVER_MATCH = CNT_WIDTH'(VEC_WIDTH + 1);

    typedef struct packed {
        logic [VEC_WIDTH-1:0] vec;
        logic [ID_WIDTH-1:0]  id;
    } cand_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        logic [REF_NUM-1:0]  mask;
        logic                last;
    } mask_item_t;

    typedef struct packed {
        logic [REF_IDX_WIDTH-1:0] ref_idx;
        logic [ID_WIDTH-1:0]      id;
        logic                     last;
    } pair_t;

    typedef struct packed {
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [SUM_WIDTH-1:0] paddr;
        logic [CNT_WIDTH-1:0] pwdata;
    } apb_req_t;

    function automatic logic [CNT_WIDTH-1:0] popcount(input logic [VEC_WIDTH-1:0] vec);
        logic [CNT_WIDTH-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < VEC_WIDTH; i++) begin
            cnt = cnt + CNT_WIDTH'(vec[i]);
        end
        return cnt;
    endfunction

endpackage
